// ==== verilog/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

	//////////////////////////////
	// 640x480 raster timing
	//////////////////////////////

	// Horizontal, in pixels
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// Vertical, in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	//////////////////////////////
	// Types
	//////////////////////////////

	// Pixel or line position inside the full raster
	typedef logic [9:0] pix_count_t;

	// 4 bits each of red, green, blue
	typedef logic [11:0] rgb12_t;

endpackage

`default_nettype wire

// ==== verilog/debug_view_pkg.sv ====
`default_nettype none

package debug_view_pkg;

	//////////////////////////////
	// Text grid geometry
	//////////////////////////////

	// One character cell
	localparam int CELL_W = 8;
	localparam int CELL_H = 16;

	// Screen is four pages side by side
	localparam int PAGE_COLS = 20;

	// Screen rows carrying register lines
	localparam int FIRST_ROW = 2;
	localparam int LAST_ROW  = 9;

	// Column offsets inside a page
	localparam int LABEL_COL = 2;
	localparam int VALUE_COL = 10;

	//////////////////////////////
	// Register map
	//////////////////////////////

	localparam int REG_COUNT = 32;
	localparam int ADDR_FG   = 32;
	localparam int ADDR_BG   = 33;

	// White text on red
	localparam logic [11:0] FG_RESET = 12'hFFF;
	localparam logic [11:0] BG_RESET = 12'hF00;

	typedef logic [5:0]  reg_addr_t;
	typedef logic [4:0]  reg_index_t;
	typedef logic [31:0] debug_word_t;
	typedef logic [6:0]  char_code_t;

endpackage

`default_nettype wire

// ==== verilog/vga_sync_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_sync_gen (
	input  logic                clk,
	input  logic                rst_n,
	output vga_pkg::pix_count_t h_count,
	output vga_pkg::pix_count_t v_count,
	output logic                hsync_raw,
	output logic                vsync_raw,
	output logic                active_raw
);
	import vga_pkg::*;

	logic h_last;
	logic v_last;
	logic in_hsync;
	logic in_vsync;

	assign h_last = (h_count == pix_count_t'(H_TOTAL - 1));
	assign v_last = (v_count == pix_count_t'(V_TOTAL - 1));

	//////////////////////////////
	// Pixel and line counters
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			h_count <= '0;
		end else if (h_last) begin
			h_count <= '0;
		end else begin
			h_count <= h_count + pix_count_t'(1);
		end
	end

	// Line advances on the last pixel of each line
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v_count <= '0;
		end else if (h_last) begin
			if (v_last) begin
				v_count <= '0;
			end else begin
				v_count <= v_count + pix_count_t'(1);
			end
		end
	end

	//////////////////////////////
	// Sync and active windows
	//////////////////////////////

	// Sync pulse sits after the front porch
	assign in_hsync = (h_count >= pix_count_t'(H_ACTIVE + H_FRONT)) &&
		(h_count < pix_count_t'(H_ACTIVE + H_FRONT + H_SYNC));
	assign in_vsync = (v_count >= pix_count_t'(V_ACTIVE + V_FRONT)) &&
		(v_count < pix_count_t'(V_ACTIVE + V_FRONT + V_SYNC));

	// Both syncs are active low
	assign hsync_raw = ~in_hsync;
	assign vsync_raw = ~in_vsync;

	assign active_raw = (h_count < pix_count_t'(H_ACTIVE)) &&
		(v_count < pix_count_t'(V_ACTIVE));

endmodule

`default_nettype wire

// ==== verilog/debug_reg_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module debug_reg_bank (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        wr_en,
	input  debug_view_pkg::reg_addr_t   wr_addr,
	input  debug_view_pkg::debug_word_t wr_data,
	input  debug_view_pkg::reg_index_t  read_index,
	output debug_view_pkg::debug_word_t read_data,
	output vga_pkg::rgb12_t             fg_colour,
	output vga_pkg::rgb12_t             bg_colour
);
	import debug_view_pkg::*;

	debug_word_t words [REG_COUNT];

	logic hit_word;
	logic hit_fg;
	logic hit_bg;

	//////////////////////////////
	// Write decode
	//////////////////////////////

	// Addresses past the colour pair fall through unused
	assign hit_word = wr_en && (wr_addr < reg_addr_t'(REG_COUNT));
	assign hit_fg   = wr_en && (wr_addr == reg_addr_t'(ADDR_FG));
	assign hit_bg   = wr_en && (wr_addr == reg_addr_t'(ADDR_BG));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				words[i] <= '0;
			end
		end else if (hit_word) begin
			words[wr_addr[4:0]] <= wr_data;
		end
	end

	// Colour registers keep only the low 12 bits
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fg_colour <= FG_RESET;
			bg_colour <= BG_RESET;
		end else begin
			if (hit_fg) begin
				fg_colour <= wr_data[11:0];
			end
			if (hit_bg) begin
				bg_colour <= wr_data[11:0];
			end
		end
	end

	//////////////////////////////
	// Renderer read port
	//////////////////////////////

	assign read_data = words[read_index];

endmodule

`default_nettype wire

// ==== verilog/glyph_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module glyph_rom (
	input  logic                       clk,
	input  debug_view_pkg::char_code_t char_code,
	input  logic [3:0]                 glyph_row,
	output logic [7:0]                 glyph_bits
);

	// Whole 8x16 glyph, row 0 in the top byte
	logic [127:0] glyph;

	//////////////////////////////
	// Font table
	//////////////////////////////

	always_comb begin
		case (char_code)
			// Digits
			7'h30: glyph = 128'h0000_7CC6_C6CE_DEF6_E6C6_C67C_0000_0000;
			7'h31: glyph = 128'h0000_1838_7818_1818_1818_187E_0000_0000;
			7'h32: glyph = 128'h0000_7CC6_060C_1830_60C0_C6FE_0000_0000;
			7'h33: glyph = 128'h0000_7CC6_0606_3C06_0606_C67C_0000_0000;
			7'h34: glyph = 128'h0000_0C1C_3C6C_CCFE_0C0C_0C1E_0000_0000;
			7'h35: glyph = 128'h0000_FEC0_C0C0_FC06_0606_C67C_0000_0000;
			7'h36: glyph = 128'h0000_3860_C0C0_FCC6_C6C6_C67C_0000_0000;
			7'h37: glyph = 128'h0000_FEC6_0606_0C18_3030_3030_0000_0000;
			7'h38: glyph = 128'h0000_7CC6_C6C6_7CC6_C6C6_C67C_0000_0000;
			7'h39: glyph = 128'h0000_7CC6_C6C6_7E06_0606_0C78_0000_0000;
			// Hex letters
			7'h41: glyph = 128'h0000_1038_6CC6_C6FE_C6C6_C6C6_0000_0000;
			7'h42: glyph = 128'h0000_FC66_6666_7C66_6666_66FC_0000_0000;
			7'h43: glyph = 128'h0000_3C66_C2C0_C0C0_C0C2_663C_0000_0000;
			7'h44: glyph = 128'h0000_F86C_6666_6666_6666_6CF8_0000_0000;
			7'h45: glyph = 128'h0000_FE66_6268_7868_6062_66FE_0000_0000;
			7'h46: glyph = 128'h0000_FE66_6268_7868_6060_60F0_0000_0000;
			// Remaining label letters
			7'h47: glyph = 128'h0000_3C66_C2C0_C0DE_C6C6_663A_0000_0000;
			7'h52: glyph = 128'h0000_FC66_6666_7C6C_6666_66E6_0000_0000;
			// Minus sign
			7'h2D: glyph = 128'h0000_0000_0000_00FE_0000_0000_0000_0000;
			// Space and anything unsupported
			default: glyph = '0;
		endcase
	end

	//////////////////////////////
	// Registered row output
	//////////////////////////////

	// Row r occupies bits 127-8r down to 120-8r
	always_ff @(posedge clk) begin
		glyph_bits <= glyph[{~glyph_row, 3'b000} +: 8];
	end

endmodule

`default_nettype wire

// ==== verilog/debug_text_render.sv ====
`timescale 1ns/1ns
`default_nettype none

module debug_text_render (
	input  logic                        clk,
	input  logic                        rst_n,
	input  vga_pkg::pix_count_t         h_count,
	input  vga_pkg::pix_count_t         v_count,
	input  logic                        hsync_raw,
	input  logic                        vsync_raw,
	input  logic                        active_raw,
	output debug_view_pkg::reg_index_t  read_index,
	input  debug_view_pkg::debug_word_t read_data,
	input  vga_pkg::rgb12_t             fg_colour,
	input  vga_pkg::rgb12_t             bg_colour,
	output vga_pkg::rgb12_t             rgb,
	output logic                        hsync,
	output logic                        vsync,
	output logic                        de
);
	import vga_pkg::*;
	import debug_view_pkg::*;

	logic [5:0]  cell_row;
	logic [5:0]  row_rel;
	logic [6:0]  cell_col;
	logic [1:0]  page;
	logic [4:0]  col_in_page;
	logic [3:0]  line_in_cell;
	logic [4:0]  label_pos;
	logic [2:0]  digit_pos;
	logic        text_row;
	logic        latch_win;
	reg_index_t  cell_index;
	debug_word_t word_buf [4];
	debug_word_t page_word;
	char_code_t  char_next;

	char_code_t  char_s1;
	logic [3:0]  glyph_row_s1;
	logic [2:0]  pix_col_s1;
	logic        active_s1;
	logic        hsync_s1;
	logic        vsync_s1;

	logic [7:0]  glyph_bits;
	logic [2:0]  pix_col_s2;
	logic        active_s2;
	logic        hsync_s2;
	logic        vsync_s2;

	function automatic char_code_t hex_char(input logic [3:0] nib);
		if (nib < 4'd10) begin
			return 7'h30 + {3'b000, nib};
		end
		// 'A' sits 7 codes past '9'+1
		return 7'h37 + {3'b000, nib};
	endfunction

	//////////////////////////////
	// Cell addressing
	//////////////////////////////

	assign cell_row     = 6'(v_count / CELL_H);
	assign line_in_cell = 4'(v_count % CELL_H);
	assign cell_col     = 7'(h_count / CELL_W);
	assign page         = 2'(cell_col / PAGE_COLS);
	assign col_in_page  = 5'(cell_col % PAGE_COLS);
	assign row_rel      = cell_row - 6'(FIRST_ROW);
	assign text_row     = (cell_row >= 6'(FIRST_ROW)) && (cell_row <= 6'(LAST_ROW));
	assign cell_index   = {row_rel[2:0], page};

	//////////////////////////////
	// Row word latch
	//////////////////////////////

	// Pages 0..3 are stepped by h_count 640..643 on the row's top line
	assign read_index = {row_rel[2:0], h_count[1:0]};
	assign latch_win  = text_row && (line_in_cell == 4'd0) &&
		(h_count >= pix_count_t'(H_ACTIVE)) && (h_count < pix_count_t'(H_ACTIVE + 4));

	always_ff @(posedge clk) begin
		if (latch_win) begin
			word_buf[h_count[1:0]] <= read_data;
		end
	end

	assign page_word = word_buf[page];

	//////////////////////////////
	// Character selection
	//////////////////////////////

	assign label_pos = col_in_page - 5'(LABEL_COL);
	assign digit_pos = 3'(col_in_page - 5'(VALUE_COL));

	always_comb begin
		char_next = 7'h20;
		if (active_raw && text_row) begin
			if (col_in_page >= 5'(LABEL_COL) && col_in_page < 5'(LABEL_COL + 6)) begin
				// REG-xx
				case (label_pos)
					5'd0: char_next = 7'h52;
					5'd1: char_next = 7'h45;
					5'd2: char_next = 7'h47;
					5'd3: char_next = 7'h2D;
					5'd4: char_next = hex_char({3'b000, cell_index[4]});
					default: char_next = hex_char(cell_index[3:0]);
				endcase
			end else if (col_in_page >= 5'(VALUE_COL) && col_in_page < 5'(VALUE_COL + 8)) begin
				// Most significant nibble first
				char_next = hex_char(page_word[{~digit_pos, 2'b00} +: 4]);
			end
		end
	end

	//////////////////////////////
	// Stage 1, character
	//////////////////////////////

	always_ff @(posedge clk) begin
		char_s1      <= char_next;
		glyph_row_s1 <= line_in_cell;
		pix_col_s1   <= h_count[2:0];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active_s1 <= 1'b0;
			hsync_s1  <= 1'b1;
			vsync_s1  <= 1'b1;
		end else begin
			active_s1 <= active_raw;
			hsync_s1  <= hsync_raw;
			vsync_s1  <= vsync_raw;
		end
	end

	//////////////////////////////
	// Stage 2, glyph row
	//////////////////////////////

	glyph_rom u_glyph_rom (
		.clk        (clk),
		.char_code  (char_s1),
		.glyph_row  (glyph_row_s1),
		.glyph_bits (glyph_bits)
	);

	always_ff @(posedge clk) begin
		pix_col_s2 <= pix_col_s1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active_s2 <= 1'b0;
			hsync_s2  <= 1'b1;
			vsync_s2  <= 1'b1;
		end else begin
			active_s2 <= active_s1;
			hsync_s2  <= hsync_s1;
			vsync_s2  <= vsync_s1;
		end
	end

	//////////////////////////////
	// Stage 3, colour
	//////////////////////////////

	// Bit 7 is the leftmost pixel of the cell
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rgb   <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			de    <= 1'b0;
		end else begin
			rgb   <= (active_s2 && glyph_bits[~pix_col_s2]) ? fg_colour : bg_colour;
			hsync <= hsync_s2;
			vsync <= vsync_s2;
			de    <= active_s2;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/debug_console_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module debug_console_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        wr_en,
	input  debug_view_pkg::reg_addr_t   wr_addr,
	input  debug_view_pkg::debug_word_t wr_data,
	output vga_pkg::rgb12_t             rgb,
	output logic                        hsync,
	output logic                        vsync,
	output logic                        de
);
	import vga_pkg::*;
	import debug_view_pkg::*;

	pix_count_t  h_count;
	pix_count_t  v_count;
	logic        hsync_raw;
	logic        vsync_raw;
	logic        active_raw;
	reg_index_t  read_index;
	debug_word_t read_data;
	rgb12_t      fg_colour;
	rgb12_t      bg_colour;

	// Raster timing
	vga_sync_gen u_sync (
		.clk        (clk),
		.rst_n      (rst_n),
		.h_count    (h_count),
		.v_count    (v_count),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw),
		.active_raw (active_raw)
	);

	// Host-written words and colours
	debug_reg_bank u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.read_index (read_index),
		.read_data  (read_data),
		.fg_colour  (fg_colour),
		.bg_colour  (bg_colour)
	);

	// Text overlay, three clocks behind the counters
	debug_text_render u_render (
		.clk        (clk),
		.rst_n      (rst_n),
		.h_count    (h_count),
		.v_count    (v_count),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw),
		.active_raw (active_raw),
		.read_index (read_index),
		.read_data  (read_data),
		.fg_colour  (fg_colour),
		.bg_colour  (bg_colour),
		.rgb        (rgb),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de)
	);

endmodule

`default_nettype wire

// ==== sim/clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clk_gen (
	output logic clk,
	output logic rst_n
);
	localparam int HALF_PERIOD  = 4;
	localparam int RESET_CYCLES = 5;
	localparam int DRIVE_DELAY  = 1;

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Released just after the fifth rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== sim/tb_debug_console.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_debug_console;

	// 640x480 raster at one pixel per clock
	localparam int     ACTIVE_PIX   = 640;
	localparam int     ACTIVE_LINES = 480;
	localparam int     LINE_CLKS    = 800;
	localparam int     HSYNC_CLKS   = 96;
	localparam int     FRAME_LINES  = 525;
	localparam int     VSYNC_LINES  = 2;
	localparam int     CLK_NS       = 8;
	localparam int     DRIVE_DELAY  = 1;
	localparam longint FRAME_NS     = longint'(LINE_CLKS * FRAME_LINES * CLK_NS);
	localparam string  INPUT_FILE   = "sim/debug_console_input.txt";

	logic        clk;
	logic        rst_n;
	logic        wr_en;
	logic [5:0]  wr_addr;
	logic [31:0] wr_data;
	logic [11:0] rgb;
	logic        hsync;
	logic        vsync;
	logic        de;

	// Commands from the input file
	byte cmd_kind [$];
	int  arg_a [$];
	int  arg_b [$];
	int  arg_c [$];

	// Pixel position rebuilt from de and the syncs
	int          x_cnt;
	int          y_cnt;
	int          cur_x;
	int          cur_y;
	logic        cur_valid;
	logic [11:0] cur_rgb;
	logic        in_vblank;
	logic        de_prev;
	logic        hsync_prev;
	logic        vsync_prev;

	// Raster timing measurement
	int          line_clks;
	int          hsync_low;
	int          frame_clks;
	int          vsync_low;
	logic        seen_hsync;
	logic        seen_vsync;

	longint      watchdog_ns;

	clk_gen u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	debug_console_top dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rgb     (rgb),
		.hsync   (hsync),
		.vsync   (vsync),
		.de      (de)
	);

	task automatic abort_run(input string reason);
		$display("error at %0t ns: %s", $time, reason);
		$display(">>> FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1, "check failed");
		end
	endtask

	//////////////////////////////
	// Raster tracking, one clock per call
	//////////////////////////////

	task automatic advance();
		@(posedge clk);
		cur_valid = de;
		if (de) begin
			cur_x     = x_cnt;
			cur_y     = y_cnt;
			cur_rgb   = rgb;
			x_cnt     = x_cnt + 1;
			in_vblank = 1'b0;
		end
		// End of a visible line
		if (de_prev && !de) begin
			check_value("de pixels in line", x_cnt, ACTIVE_PIX);
			x_cnt = 0;
			y_cnt = y_cnt + 1;
			if (y_cnt == ACTIVE_LINES) begin
				in_vblank = 1'b1;
			end
		end
		line_clks  = line_clks + 1;
		frame_clks = frame_clks + 1;
		if (!hsync) begin
			hsync_low = hsync_low + 1;
		end
		if (!vsync) begin
			vsync_low = vsync_low + 1;
		end
		if (hsync_prev && !hsync) begin
			if (seen_hsync) begin
				check_value("hsync period in clk", line_clks, LINE_CLKS);
			end
			seen_hsync = 1'b1;
			line_clks  = 0;
		end
		if (!hsync_prev && hsync) begin
			check_value("hsync low width in clk", hsync_low, HSYNC_CLKS);
			hsync_low = 0;
		end
		// New frame starts counting lines from here
		if (vsync_prev && !vsync) begin
			check_value("de lines in frame", y_cnt, ACTIVE_LINES);
			if (seen_vsync) begin
				check_value("frame period in clk", frame_clks, LINE_CLKS * FRAME_LINES);
			end
			seen_vsync = 1'b1;
			frame_clks = 0;
			y_cnt      = 0;
		end
		if (!vsync_prev && vsync) begin
			check_value("vsync low width in clk", vsync_low, VSYNC_LINES * LINE_CLKS);
			vsync_low = 0;
		end
		de_prev    = de;
		hsync_prev = hsync;
		vsync_prev = vsync;
	endtask

	task automatic apply_write(input logic [5:0] addr, input logic [31:0] data);
		while (!in_vblank) begin
			advance();
		end
		#(DRIVE_DELAY);
		wr_en   = 1'b1;
		wr_addr = addr;
		wr_data = data;
		advance();
		#(DRIVE_DELAY);
		wr_en = 1'b0;
	endtask

	task automatic check_sample(input int x, input int y, input int exp);
		do begin
			advance();
		end while (!(cur_valid && cur_x == x && cur_y == y));
		check_value($sformatf("rgb at (%0d,%0d)", x, y), int'(cur_rgb), exp);
	endtask

	task automatic load_commands();
		int            fd;
		int            code;
		int            a;
		int            b;
		int            c;
		logic [63:0]   token;
		logic [1023:0] rest;
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			abort_run("cannot open the input file");
		end
		while ($fscanf(fd, "%s", token) == 1) begin
			if (token[63:8] != '0) begin
				abort_run("input file has a command word longer than one letter");
			end else if (token[7:0] == "#") begin
				code = $fgets(rest, fd);
			end else if (token[7:0] == "w") begin
				code = $fscanf(fd, "%h %h", a, b);
				if (code != 2) begin
					abort_run("write line in the input file is incomplete");
				end
				cmd_kind.push_back("w");
				arg_a.push_back(a);
				arg_b.push_back(b);
				arg_c.push_back(0);
			end else if (token[7:0] == "s") begin
				code = $fscanf(fd, "%d %d %h", a, b, c);
				if (code != 3) begin
					abort_run("sample line in the input file is incomplete");
				end
				cmd_kind.push_back("s");
				arg_a.push_back(a);
				arg_b.push_back(b);
				arg_c.push_back(c);
			end else begin
				abort_run("input file holds an unknown command");
			end
		end
		$fclose(fd);
	endtask

	// Three frames for each group of samples, two more for the writes
	initial begin : watchdog
		wait (watchdog_ns > 0);
		#(watchdog_ns);
		abort_run("timeout while waiting for a sampled pixel");
	end

	initial begin
		int groups;
		wr_en      = 1'b0;
		wr_addr    = '0;
		wr_data    = '0;
		x_cnt      = 0;
		y_cnt      = 0;
		cur_x      = 0;
		cur_y      = 0;
		cur_valid  = 1'b0;
		cur_rgb    = '0;
		in_vblank  = 1'b0;
		de_prev    = 1'b0;
		hsync_prev = 1'b1;
		vsync_prev = 1'b1;
		line_clks  = 0;
		hsync_low  = 0;
		frame_clks = 0;
		vsync_low  = 0;
		seen_hsync = 1'b0;
		seen_vsync = 1'b0;
		load_commands();
		groups = 0;
		for (int i = 0; i < cmd_kind.size(); i++) begin
			if (cmd_kind[i] == "s" && (i == 0 || cmd_kind[i - 1] != "s")) begin
				groups = groups + 1;
			end
		end
		watchdog_ns = longint'(groups * 3 + 2) * FRAME_NS;
		// Outputs hold their reset values only once reset has been seen
		wait (rst_n === 1'b1);
		for (int i = 0; i < cmd_kind.size(); i++) begin
			if (cmd_kind[i] == "w") begin
				apply_write(6'(arg_a[i]), 32'(arg_b[i]));
			end else begin
				check_sample(arg_a[i], arg_b[i], arg_c[i]);
			end
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/debug_console_input.txt ====
# w <addr hex> <data hex>       host write, applied in vertical blanking
# s <x dec> <y dec> <rgb hex>   pixel at (x,y) and its expected colour
# Reset state with zeros in every value cell
s 4 20 f00
s 16 34 fff
s 22 34 f00
s 80 37 fff
s 40 39 fff
s 217 54 fff
s 616 146 f00
s 529 155 fff
s 540 155 f00
s 85 165 f00
s 639 479 f00
# Words 0, 5 and 31, then an address past the colour pair
w 00 f1000005
w 05 3a000000
w 1f 0000001f
w 28 ffffffff
s 80 34 fff
s 87 34 f00
s 91 34 fff
s 98 37 f00
s 141 39 fff
s 251 50 fff
s 245 52 fff
s 80 69 fff
s 611 146 fff
s 616 146 fff
# Blue text on green
w 20 0000000f
w 21 000000f0
s 4 20 0f0
s 16 34 00f
s 22 34 0f0
s 616 146 00f
s 639 479 0f0

// ==== sources.f ====
verilog/vga_pkg.sv
verilog/debug_view_pkg.sv
verilog/vga_sync_gen.sv
verilog/debug_reg_bank.sv
verilog/glyph_rom.sv
verilog/debug_text_render.sv
verilog/debug_console_top.sv
sim/clk_gen.sv
sim/tb_debug_console.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_debug_console
RTL_TOP   ?= debug_console_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= >>> FAIL
PASS_MSG  ?= >>> PASS

RTL_SRCS  ?= verilog/vga_pkg.sv verilog/debug_view_pkg.sv verilog/vga_sync_gen.sv \
	verilog/debug_reg_bank.sv verilog/glyph_rom.sv verilog/debug_text_render.sv \
	verilog/debug_console_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
